/* nic_rx_config.svh */
`ifndef NIC_RX_CONFIG_SVH
`define NIC_RX_CONFIG_SVH

//----------------------------------------------------------------------
// Receive buffer geometry
//----------------------------------------------------------------------

// Qword address width of the circular buffer
`define NIC_BUF_ADDR_BITS 6

// 64 qwords with the default width
`define NIC_BUF_DEPTH (1 << `NIC_BUF_ADDR_BITS)

//----------------------------------------------------------------------
// Transfer trigger tuning
//----------------------------------------------------------------------

// Qwords in one full DMA burst
`define NIC_TLP_MAX_QWORDS 16

// Quiet cycles after the last commit before a partial burst goes out
`define NIC_TRIGGER_TIMEOUT 32

`endif

/* nic_rx_pkg.sv */
`include "nic_rx_config.svh"

package nic_rx_pkg;

    //----------------------------------------------------------------------
    // Data path vectors
    //----------------------------------------------------------------------
    typedef logic [63:0] qword_t;                           // One MAC beat
    typedef logic [7:0]  byte_valid_t;                      // Per-byte valid mask

    typedef logic [`NIC_BUF_ADDR_BITS-1:0] buf_addr_t;      // Buffer word address
    typedef logic [`NIC_BUF_ADDR_BITS:0]   buf_ptr_t;       // Address plus wrap bit

    typedef logic [4:0]  qword_count_t;                     // 0 to 16 qwords per burst
    typedef logic [31:0] frame_count_t;                     // Statistics counter

    //----------------------------------------------------------------------
    // State machines
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {
        RX_IDLE,                                            // Between frames
        RX_RECEIVE,                                         // Writing beats of a frame
        RX_DROP                                             // Discarding an overflowed frame
    } rx_state_t;

    typedef enum logic [1:0] {
        TRIG_WATCH,                                         // Looking at pending qwords
        TRIG_REQUEST,                                       // Request held until ack
        TRIG_WAIT_CONSUME                                   // Waiting for new read pointer
    } trig_state_t;

endpackage

/* rx_buffer_ram.sv */
`timescale 1ns/1ps
`include "nic_rx_config.svh"

module rx_buffer_ram
    import nic_rx_pkg::*;
(
    input  logic      xaui_clk_156_25_out,                  // Single clock for both ports

    // Write port from the frame writer
    input  logic      wr_en,
    input  buf_addr_t wr_addr,
    input  qword_t    wr_data,

    // Read port for the DMA consumer
    input  buf_addr_t rd_addr,
    output qword_t    rd_data                               // Valid one cycle after rd_addr
);

    //----------------------------------------------------------------------
    // Storage
    //----------------------------------------------------------------------
    qword_t mem [`NIC_BUF_DEPTH];                           // Circular receive buffer

    // Write side
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;                        // Beat lands at end of its cycle
        end
    end

    // Read side, one register stage
    always_ff @(posedge xaui_clk_156_25_out) begin
        rd_data <= mem[rd_addr];                            // Old data on same-address collision
    end

endmodule

/* rx_frame_writer.sv */
`timescale 1ns/1ps
`include "nic_rx_config.svh"

module rx_frame_writer
    import nic_rx_pkg::*;
(
    input  logic        xaui_clk_156_25_out,
    input  logic        reset_n,

    // MAC receive client
    input  qword_t      rx_data,
    input  byte_valid_t rx_data_valid,                      // Any bit set marks a beat
    input  logic        rx_good_frame,                      // End pulse, commit
    input  logic        rx_bad_frame,                       // End pulse, roll back

    // Read pointer returned by the consumer
    input  logic        rd_addr_change,
    input  buf_ptr_t    rd_addr_extended,

    // Buffer write port
    output logic        wr_en,
    output buf_addr_t   wr_addr,
    output qword_t      wr_data,

    output buf_ptr_t    committed_wr_ptr,                   // End of last good frame
    output logic        frame_dropped                       // One cycle after dropped frame ends
);

    //----------------------------------------------------------------------
    // Local state
    //----------------------------------------------------------------------
    rx_state_t state;
    buf_ptr_t  wr_ptr;                                      // Running pointer inside a frame
    buf_ptr_t  rd_ptr_committed;                            // Consumer's released position
    buf_ptr_t  used_qwords;
    logic      beat;
    logic      end_pulse;
    logic      buf_full;

    assign beat        = |rx_data_valid;
    assign end_pulse   = rx_good_frame | rx_bad_frame;
    assign used_qwords = wr_ptr - rd_ptr_committed;         // Wrap bit keeps 64 distinct from 0
    assign buf_full    = (used_qwords == buf_ptr_t'(`NIC_BUF_DEPTH));

    // Write straight through in the beat's own cycle
    assign wr_en   = beat && !buf_full && (state != RX_DROP);
    assign wr_addr = wr_ptr[`NIC_BUF_ADDR_BITS-1:0];        // Drop the wrap bit
    assign wr_data = rx_data;

    //----------------------------------------------------------------------
    // Consumer read pointer
    //----------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr_committed <= '0;
        end else if (rd_addr_change) begin
            rd_ptr_committed <= rd_addr_extended;           // Space freed by the DMA side
        end
    end

    //----------------------------------------------------------------------
    // Frame FSM
    //----------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state            <= RX_IDLE;
            wr_ptr           <= '0;
            committed_wr_ptr <= '0;
            frame_dropped    <= 1'b0;
        end else begin
            frame_dropped <= 1'b0;                          // Single-cycle pulse
            case (state)
                RX_IDLE, RX_RECEIVE: begin
                    if (rx_good_frame) begin
                        committed_wr_ptr <= wr_ptr;         // Publish the whole frame
                        state            <= RX_IDLE;
                    end else if (rx_bad_frame) begin
                        wr_ptr <= committed_wr_ptr;         // Roll back the partial frame
                        state  <= RX_IDLE;
                    end else if (beat) begin
                        if (buf_full) begin
                            state <= RX_DROP;               // No room, lose the frame whole
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                            state  <= RX_RECEIVE;
                        end
                    end
                end
                RX_DROP: begin
                    if (end_pulse) begin
                        wr_ptr        <= committed_wr_ptr;  // Rewind what was written
                        frame_dropped <= 1'b1;
                        state         <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // Writes never land on qwords the consumer has not released
    a_no_overrun: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        wr_en |-> (used_qwords < buf_ptr_t'(`NIC_BUF_DEPTH))
    );

    // MAC gives one outcome per frame
    a_single_end_pulse: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        !(rx_good_frame && rx_bad_frame)
    );

endmodule

/* tlp_trigger.sv */
`timescale 1ns/1ps
`include "nic_rx_config.svh"

module tlp_trigger
    import nic_rx_pkg::*;
(
    input  logic         xaui_clk_156_25_out,
    input  logic         reset_n,

    input  buf_ptr_t     committed_wr_ptr,                  // From the frame writer

    // Read pointer returned by the consumer
    input  logic         rd_addr_change,
    input  buf_ptr_t     rd_addr_extended,

    // Level request with one-cycle ack
    input  logic         trigger_tlp_ack,
    output logic         trigger_tlp,
    output qword_count_t qwords_to_send                     // Held while trigger_tlp is high
);

    //----------------------------------------------------------------------
    // Pending qwords and idle timer
    //----------------------------------------------------------------------
    localparam int TIMER_BITS = $clog2(`NIC_TRIGGER_TIMEOUT + 1);
    localparam logic [TIMER_BITS-1:0] TIMEOUT_VAL = `NIC_TRIGGER_TIMEOUT;

    trig_state_t           state;
    buf_ptr_t              rd_ptr_committed;
    buf_ptr_t              last_wr_ptr;                     // Write pointer seen last cycle
    buf_ptr_t              pending;
    logic [TIMER_BITS-1:0] idle_cnt;
    logic                  commit_seen;
    logic                  timeout_hit;
    logic                  burst_ready;

    assign pending     = committed_wr_ptr - rd_ptr_committed;
    assign commit_seen = (committed_wr_ptr != last_wr_ptr); // New frame just committed
    assign timeout_hit = (idle_cnt == TIMEOUT_VAL) && !commit_seen;
    assign burst_ready = (pending >= buf_ptr_t'(`NIC_TLP_MAX_QWORDS));

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr_committed <= '0;
            last_wr_ptr      <= '0;
            idle_cnt         <= '0;
        end else begin
            last_wr_ptr <= committed_wr_ptr;
            if (rd_addr_change) begin
                rd_ptr_committed <= rd_addr_extended;       // Consumer finished a burst
            end
            if (commit_seen) begin
                idle_cnt <= '0;                             // Restart quiet period
            end else if (idle_cnt != TIMEOUT_VAL) begin
                idle_cnt <= idle_cnt + 1'b1;                // Saturates at the timeout
            end
        end
    end

    //----------------------------------------------------------------------
    // Request FSM
    //----------------------------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state          <= TRIG_WATCH;
            trigger_tlp    <= 1'b0;
            qwords_to_send <= '0;
        end else begin
            case (state)
                TRIG_WATCH: begin
                    if (burst_ready) begin
                        trigger_tlp    <= 1'b1;
                        qwords_to_send <= qword_count_t'(`NIC_TLP_MAX_QWORDS); // Full burst
                        state          <= TRIG_REQUEST;
                    end else if ((pending != '0) && timeout_hit) begin
                        trigger_tlp    <= 1'b1;
                        qwords_to_send <= qword_count_t'(pending);  // Remainder below 16
                        state          <= TRIG_REQUEST;
                    end
                end
                TRIG_REQUEST: begin
                    if (trigger_tlp_ack) begin
                        trigger_tlp <= 1'b0;                // Drop at the edge after ack
                        state       <= TRIG_WAIT_CONSUME;
                    end
                end
                TRIG_WAIT_CONSUME: begin
                    if (rd_addr_change) begin
                        state <= TRIG_WATCH;                // Pending recomputed next cycle
                    end
                end
                default: begin
                    state <= TRIG_WATCH;
                end
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // Request stays up with a fixed size until the consumer answers
    a_req_held: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        (trigger_tlp && !trigger_tlp_ack) |=> (trigger_tlp && $stable(qwords_to_send))
    );

    a_req_size: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp |-> ((qwords_to_send >= 5'd1) && (qwords_to_send <= 5'd16))
    );

    // Consumer acks only an open request
    a_ack_has_req: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp_ack |-> trigger_tlp
    );

endmodule

/* rx_frame_counters.sv */
`timescale 1ns/1ps

module rx_frame_counters
    import nic_rx_pkg::*;
(
    input  logic         xaui_clk_156_25_out,
    input  logic         reset_n,

    // Frame outcome pulses
    input  logic         rx_good_frame,                     // From the MAC
    input  logic         rx_bad_frame,                      // From the MAC
    input  logic         frame_dropped,                     // From the frame writer

    output frame_count_t good_frames,
    output frame_count_t bad_frames,
    output frame_count_t dropped_frames
);

    //----------------------------------------------------------------------
    // Statistics
    //----------------------------------------------------------------------
    // A dropped frame also shows up in good or bad
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            good_frames    <= '0;
            bad_frames     <= '0;
            dropped_frames <= '0;
        end else begin
            if (rx_good_frame) begin
                good_frames <= good_frames + 1'b1;
            end
            if (rx_bad_frame) begin
                bad_frames <= bad_frames + 1'b1;
            end
            if (frame_dropped) begin
                dropped_frames <= dropped_frames + 1'b1;    // Overflow losses
            end
        end
    end

endmodule

/* nic_rx_top.sv */
`timescale 1ns/1ps

module nic_rx_top
    import nic_rx_pkg::*;
(
    input  logic         xaui_clk_156_25_out,
    input  logic         reset_n,

    // MAC receive client
    input  qword_t       rx_data,
    input  byte_valid_t  rx_data_valid,
    input  logic         rx_good_frame,
    input  logic         rx_bad_frame,

    // DMA consumer
    input  buf_addr_t    rd_addr,
    output qword_t       rd_data,
    input  logic         rd_addr_change,
    input  buf_ptr_t     rd_addr_extended,
    input  logic         trigger_tlp_ack,
    output logic         trigger_tlp,
    output qword_count_t qwords_to_send,

    output buf_ptr_t     committed_wr_ptr,

    // Statistics
    output frame_count_t good_frames,
    output frame_count_t bad_frames,
    output frame_count_t dropped_frames
);

    //----------------------------------------------------------------------
    // Internal wires
    //----------------------------------------------------------------------
    logic      wr_en;
    buf_addr_t wr_addr;
    qword_t    wr_data;
    logic      frame_dropped;

    rx_frame_writer u_writer (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),         // I
        .reset_n             (reset_n),                     // I
        .rx_data             (rx_data),                     // I [63:0]
        .rx_data_valid       (rx_data_valid),               // I [7:0]
        .rx_good_frame       (rx_good_frame),               // I
        .rx_bad_frame        (rx_bad_frame),                // I
        .rd_addr_change      (rd_addr_change),              // I
        .rd_addr_extended    (rd_addr_extended),            // I wrap bit included
        .wr_en               (wr_en),                       // O
        .wr_addr             (wr_addr),                     // O
        .wr_data             (wr_data),                     // O [63:0]
        .committed_wr_ptr    (committed_wr_ptr),            // O
        .frame_dropped       (frame_dropped)                // O
    );

    rx_buffer_ram u_ram (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),         // I
        .wr_en               (wr_en),                       // I
        .wr_addr             (wr_addr),                     // I
        .wr_data             (wr_data),                     // I [63:0]
        .rd_addr             (rd_addr),                     // I from consumer
        .rd_data             (rd_data)                      // O [63:0]
    );

    tlp_trigger u_trigger (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),         // I
        .reset_n             (reset_n),                     // I
        .committed_wr_ptr    (committed_wr_ptr),            // I
        .rd_addr_change      (rd_addr_change),              // I
        .rd_addr_extended    (rd_addr_extended),            // I
        .trigger_tlp_ack     (trigger_tlp_ack),             // I
        .trigger_tlp         (trigger_tlp),                 // O
        .qwords_to_send      (qwords_to_send)               // O [4:0]
    );

    rx_frame_counters u_counters (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),         // I
        .reset_n             (reset_n),                     // I
        .rx_good_frame       (rx_good_frame),               // I
        .rx_bad_frame        (rx_bad_frame),                // I
        .frame_dropped       (frame_dropped),               // I
        .good_frames         (good_frames),                 // O [31:0]
        .bad_frames          (bad_frames),                  // O [31:0]
        .dropped_frames      (dropped_frames)               // O [31:0]
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,                      // 125 MHz bench clock
    parameter int  RESET_CYCLES = 3                         // Rising edges with reset held
) (
    output logic xaui_clk_156_25_out,
    output logic reset_n
);

    initial begin
        xaui_clk_156_25_out = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) xaui_clk_156_25_out = ~xaui_clk_156_25_out;
        end
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge xaui_clk_156_25_out);
        @(negedge xaui_clk_156_25_out);
        reset_n = 1'b1;
    end

endmodule

/* nic_rx_tb.sv */
`timescale 1ns/1ps
`include "nic_rx_config.svh"

module nic_rx_tb
    import nic_rx_pkg::*;
();

    //----------------------------------------------------------------------
    // Bench constants and test table
    //----------------------------------------------------------------------
    localparam int NUM_ROWS = 6;
    localparam int DEPTH    = `NIC_BUF_DEPTH;
    localparam int MAX_QW   = `NIC_TLP_MAX_QWORDS;
    localparam int TIMEOUT  = `NIC_TRIGGER_TIMEOUT;

    typedef struct packed {
        logic [31:0] len;                                   // Frame length in qwords
        logic        good_end;                              // 1 good pulse, 0 bad pulse
        logic        drain;                                 // Consumer empties the buffer after
        logic [31:0] exp_good;                              // Counter values after the row
        logic [31:0] exp_bad;
        logic [31:0] exp_dropped;
    } test_row_t;

    test_row_t rows [NUM_ROWS];

    //----------------------------------------------------------------------
    // DUT signals
    //----------------------------------------------------------------------
    logic         xaui_clk_156_25_out;
    logic         reset_n;
    qword_t       rx_data;
    byte_valid_t  rx_data_valid;
    logic         rx_good_frame;
    logic         rx_bad_frame;
    buf_addr_t    rd_addr;
    qword_t       rd_data;
    logic         rd_addr_change;
    buf_ptr_t     rd_addr_extended;
    logic         trigger_tlp_ack;
    logic         trigger_tlp;
    qword_count_t qwords_to_send;
    buf_ptr_t     committed_wr_ptr;
    frame_count_t good_frames;
    frame_count_t bad_frames;
    frame_count_t dropped_frames;

    // Reference model state
    qword_t ref_q [$];                                      // Accepted qwords in read order
    qword_t frame_buf [0:127];                              // Current frame's beats
    int     tb_commit_ptr;                                  // Unwrapped committed write position
    int     tb_rd_ptr;                                      // Unwrapped consumer read position
    int     error_count;
    int     watchdog_cycles;
    logic   drain_active;                                   // Consumer allowed to serve requests
    integer seed;

    tb_clock_gen #(
        .PERIOD_NS    (8.0),
        .RESET_CYCLES (3)
    ) u_clk (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n)
    );

    nic_rx_top u_dut (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .rx_data             (rx_data),
        .rx_data_valid       (rx_data_valid),
        .rx_good_frame       (rx_good_frame),
        .rx_bad_frame        (rx_bad_frame),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data),
        .rd_addr_change      (rd_addr_change),
        .rd_addr_extended    (rd_addr_extended),
        .trigger_tlp_ack     (trigger_tlp_ack),
        .trigger_tlp         (trigger_tlp),
        .qwords_to_send      (qwords_to_send),
        .committed_wr_ptr    (committed_wr_ptr),
        .good_frames         (good_frames),
        .bad_frames          (bad_frames),
        .dropped_frames      (dropped_frames)
    );

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    task automatic set_row(input int idx, input int len, input logic good_end,
                           input logic drain, input int g, input int b, input int d);
        rows[idx].len         = len;
        rows[idx].good_end    = good_end;
        rows[idx].drain       = drain;
        rows[idx].exp_good    = g;
        rows[idx].exp_bad     = b;
        rows[idx].exp_dropped = d;
    endtask

    task automatic load_table();
        set_row(0, 20, 1'b1, 1'b1, 1, 0, 0);                // Burst of 16 then timeout of 4
        set_row(1,  3, 1'b1, 1'b1, 2, 0, 0);                // Short frame, timeout only
        set_row(2, 10, 1'b0, 1'b1, 2, 1, 0);                // Rolled back
        set_row(3,  5, 1'b1, 1'b1, 3, 1, 0);                // Lands where the bad frame was
        set_row(4, 40, 1'b1, 1'b0, 4, 1, 0);                // Consumer paused
        set_row(5, 30, 1'b1, 1'b1, 5, 1, 1);                // No room, dropped whole
    endtask

    // Frame lengths plus two quiet periods per row, four times over
    function automatic int run_budget();
        int total;
        int r;
        total = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            total = total + rows[r].len + 2 * TIMEOUT + 8;
        end
        return 4 * total + 16;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    //----------------------------------------------------------------------
    // MAC driver
    //----------------------------------------------------------------------
    task automatic send_frame(input int len, input logic good_end);
        int   i;
        int   used;
        logic fits;
        used = tb_commit_ptr - tb_rd_ptr;                   // Writer starts from the commit point
        fits = (used + len <= DEPTH);
        for (i = 0; i < len; i++) begin
            frame_buf[i] = {$random(seed), $random(seed)};
        end
        for (i = 0; i < len; i++) begin
            @(negedge xaui_clk_156_25_out);
            rx_data       = frame_buf[i];
            rx_data_valid = (i == len - 1) ? 8'h0F : 8'hFF; // Last beat partial
        end
        @(negedge xaui_clk_156_25_out);
        rx_data       = '0;
        rx_data_valid = '0;
        rx_good_frame = good_end;                           // End pulse one cycle after last beat
        rx_bad_frame  = !good_end;
        @(negedge xaui_clk_156_25_out);
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        if (good_end && fits) begin
            for (i = 0; i < len; i++) begin
                ref_q.push_back(frame_buf[i]);
            end
            tb_commit_ptr = tb_commit_ptr + len;
        end
    endtask

    //----------------------------------------------------------------------
    // DMA consumer model
    //----------------------------------------------------------------------
    task automatic serve_request();
        int     pending;
        int     exp_count;
        int     n;
        int     i;
        qword_t exp_data;
        pending   = tb_commit_ptr - tb_rd_ptr;
        exp_count = (pending > MAX_QW) ? MAX_QW : pending;
        n         = int'(qwords_to_send);
        check_value("qwords_to_send", qwords_to_send, exp_count);
        trigger_tlp_ack = 1'b1;
        @(negedge xaui_clk_156_25_out);
        trigger_tlp_ack = 1'b0;
        check_value("trigger_tlp", trigger_tlp, 1'b0);      // Falls at the edge after ack
        for (i = 0; i < n; i++) begin
            rd_addr = buf_addr_t'(tb_rd_ptr + i);
            @(negedge xaui_clk_156_25_out);                 // One cycle read latency
            assert (ref_q.size() != 0) else begin
                $display("Buffer read at qword %0d with no reference data left", tb_rd_ptr + i);
                error_count++;
            end
            if (ref_q.size() != 0) begin
                exp_data = ref_q.pop_front();
                check_value("rd_data", rd_data, exp_data);
            end
        end
        rd_addr_change   = 1'b1;
        rd_addr_extended = buf_ptr_t'(tb_rd_ptr + n);       // Wrap bit included
        @(negedge xaui_clk_156_25_out);
        rd_addr_change = 1'b0;
        tb_rd_ptr      = tb_rd_ptr + n;
    endtask

    initial begin : consumer
        rd_addr          = '0;
        rd_addr_change   = 1'b0;
        rd_addr_extended = '0;
        trigger_tlp_ack  = 1'b0;
        forever begin
            @(negedge xaui_clk_156_25_out);
            if (drain_active && trigger_tlp) begin
                serve_request();
            end
        end
    end

    // Let the consumer empty the buffer, then make sure nothing else is requested
    task automatic drain_buffer();
        drain_active = 1'b1;
        while (tb_rd_ptr != tb_commit_ptr) begin
            @(negedge xaui_clk_156_25_out);
        end
        drain_active = 1'b0;
        repeat (TIMEOUT + 4) @(negedge xaui_clk_156_25_out);
        assert (!trigger_tlp) else begin
            $display("Transfer request raised with nothing left to read");
            error_count++;
        end
    endtask

    //----------------------------------------------------------------------
    // Watchdog
    //----------------------------------------------------------------------
    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge xaui_clk_156_25_out);
        $display("Watchdog expired after %0d cycles, the run stopped making progress",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin : main
        int r;
        int row_errors;
        int tests_passed;
        rx_data       = '0;
        rx_data_valid = '0;
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        drain_active  = 1'b0;
        seed          = 32'h957c;
        error_count   = 0;
        tb_commit_ptr = 0;
        tb_rd_ptr     = 0;
        tests_passed  = 0;
        load_table();
        watchdog_cycles = run_budget();

        wait (reset_n === 1'b1);
        repeat (2) @(negedge xaui_clk_156_25_out);

        for (r = 0; r < NUM_ROWS; r++) begin
            row_errors = error_count;
            send_frame(rows[r].len, rows[r].good_end);
            @(negedge xaui_clk_156_25_out);                 // Dropped counter lags one cycle
            check_value("committed_wr_ptr", committed_wr_ptr, buf_ptr_t'(tb_commit_ptr));
            check_value("good_frames", good_frames, rows[r].exp_good);
            check_value("bad_frames", bad_frames, rows[r].exp_bad);
            check_value("dropped_frames", dropped_frames, rows[r].exp_dropped);
            if (rows[r].drain) begin
                drain_buffer();
            end
            if (error_count == row_errors) begin
                tests_passed++;
                $display("Test %0d: %0d qwords, good %0d, drain %0d passed",
                         r, rows[r].len, rows[r].good_end, rows[r].drain);
            end else begin
                $display("Test %0d: %0d qwords, good %0d, drain %0d failed with %0d errors",
                         r, rows[r].len, rows[r].good_end, rows[r].drain,
                         error_count - row_errors);
            end
        end

        // Everything committed has been consumed
        row_errors = error_count;
        check_value("committed_wr_ptr", committed_wr_ptr, buf_ptr_t'(tb_rd_ptr));
        check_value("good_frames", good_frames, rows[NUM_ROWS-1].exp_good);
        check_value("bad_frames", bad_frames, rows[NUM_ROWS-1].exp_bad);
        check_value("dropped_frames", dropped_frames, rows[NUM_ROWS-1].exp_dropped);
        assert (ref_q.size() == 0) else begin
            $display("%0d accepted qwords were never read back", ref_q.size());
            error_count++;
        end
        if (error_count == row_errors) begin
            tests_passed++;
            $display("Test %0d: final counters and pointers passed", NUM_ROWS);
        end else begin
            $display("Test %0d: final counters and pointers failed", NUM_ROWS);
        end

        $display("Summary: %0d of %0d tests passed, %0d errors",
                 tests_passed, NUM_ROWS + 1, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* nic_rx_top.f */
+incdir+.
nic_rx_pkg.sv
rx_buffer_ram.sv
rx_frame_writer.sv
tlp_trigger.sv
rx_frame_counters.sv
nic_rx_top.sv
tb_clock_gen.sv
nic_rx_tb.sv

/* Bender.yml */
package:
  name: nic_rx

export_include_dirs:
  - .

sources:
  - files:
      - nic_rx_pkg.sv
      - rx_buffer_ram.sv
      - rx_frame_writer.sv
      - tlp_trigger.sv
      - rx_frame_counters.sv
      - nic_rx_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - nic_rx_tb.sv
